// ==== design/isa_pkg.sv ====
package isa_pkg;

  // Register format view, used by ALU, shift and jr instructions
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_view_t;

  // Immediate format view for loads, stores, branches and ALU immediates
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
  } i_view_t;

  // Jump format view, the target is a word index inside the current 256 MB region
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target26;
  } j_view_t;

  // The same 32-bit word seen three ways
  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
    j_view_t j_view;
  } instr_t;

  localparam logic [5:0] op_special = 6'h00;  // Selects on funct
  localparam logic [5:0] op_j       = 6'h02;
  localparam logic [5:0] op_jal     = 6'h03;
  localparam logic [5:0] op_beq     = 6'h04;
  localparam logic [5:0] op_bne     = 6'h05;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_andi    = 6'h0c;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_lui     = 6'h0f;
  localparam logic [5:0] op_lb      = 6'h20;
  localparam logic [5:0] op_lh      = 6'h21;
  localparam logic [5:0] op_lw      = 6'h23;
  localparam logic [5:0] op_lbu     = 6'h24;
  localparam logic [5:0] op_lhu     = 6'h25;
  localparam logic [5:0] op_sb      = 6'h28;
  localparam logic [5:0] op_sh      = 6'h29;
  localparam logic [5:0] op_sw      = 6'h2b;

  localparam logic [5:0] fn_sll  = 6'h00;
  localparam logic [5:0] fn_srl  = 6'h02;
  localparam logic [5:0] fn_jr   = 6'h08;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_xor  = 6'h26;
  localparam logic [5:0] fn_slt  = 6'h2a;

  localparam logic [31:0] reset_vector = 32'hBFC0_0000;  // Boot ROM base of the MIPS map

endpackage

// ==== design/ctrl_pkg.sv ====
package ctrl_pkg;

  // Operation the ALU performs on its two operands
  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,  // Also used by beq and bne to produce the zero flag
    alu_and = 4'd2,
    alu_or  = 4'd3,
    alu_xor = 4'd4,
    alu_slt = 4'd5,  // Signed compare
    alu_sll = 4'd6,  // Shifts act on operand b by shamt
    alu_srl = 4'd7,
    alu_lui = 4'd8   // Immediate moved into the upper half
  } alu_op_e;

  // How the load selector turns the read word into a register value
  typedef enum logic [2:0] {
    ld_word   = 3'd0,
    ld_byte_s = 3'd1,
    ld_byte_u = 3'd2,
    ld_half_s = 3'd3,
    ld_half_u = 3'd4
  } load_kind_e;

  // Width of a store, byte and half take the read-modify-write path
  typedef enum logic [1:0] {
    st_word = 2'd0,
    st_byte = 2'd1,
    st_half = 2'd2
  } store_kind_e;

endpackage

// ==== design/alu.sv ====
`timescale 1ns/10ps

module alu (
  input  ctrl_pkg::alu_op_e op,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  input  logic [4:0]        shamt,
  output logic [31:0]       y,
  output logic              zero
);

  logic        a_lt_b;
  logic [31:0] diff;

  assign diff   = a - b;  // Shared by subu, beq and bne
  assign a_lt_b = ($signed(a) < $signed(b));

  always_comb begin
    case (op)
      ctrl_pkg::alu_add: y = a + b;
      ctrl_pkg::alu_sub: y = diff;
      ctrl_pkg::alu_and: y = a & b;
      ctrl_pkg::alu_or:  y = a | b;
      ctrl_pkg::alu_xor: y = a ^ b;
      ctrl_pkg::alu_slt: y = {31'h0, a_lt_b};
      ctrl_pkg::alu_sll: y = b << shamt;  // rt is the shifted operand
      ctrl_pkg::alu_srl: y = b >> shamt;  // Logical, zeros come in from the top
      ctrl_pkg::alu_lui: y = {b[15:0], 16'h0};
      default:           y = a + b;
    endcase
  end

  // Branches only look at this flag
  assign zero = (y == 32'h0);

endmodule

// ==== design/load_select.sv ====
`timescale 1ns/10ps

module load_select (
  input  logic [31:0]          word,
  input  logic [1:0]           byte_addr,
  input  ctrl_pkg::load_kind_e kind,
  output logic [31:0]          y
);

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  // Big-endian, so offset 0 is the most significant byte
  assign byte_lane = word[8 * (3 - byte_addr) +: 8];
  assign half_lane = byte_addr[1] ? word[15:0] : word[31:16];

  always_comb begin
    case (kind)
      ctrl_pkg::ld_byte_s: y = {{24{byte_lane[7]}}, byte_lane};
      ctrl_pkg::ld_byte_u: y = {24'h0, byte_lane};
      ctrl_pkg::ld_half_s: y = {{16{half_lane[15]}}, half_lane};
      ctrl_pkg::ld_half_u: y = {16'h0, half_lane};
      default:             y = word;
    endcase
  end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        we,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  input  logic [4:0]  wa,
  input  logic [31:0] wd,
  output logic [31:0] rd1,
  output logic [31:0] rd2,
  output logic [31:0] reg_v0
);

  logic [31:0] regs [32];

  // Register 0 is never written, so it keeps the zero from reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (we && (wa != 5'd0)) begin
      regs[wa] <= wd;
    end
  end

  // Reads are combinational, a write shows up from the next cycle on
  assign rd1 = (ra1 == 5'd0) ? 32'h0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? 32'h0 : regs[ra2];

  assign reg_v0 = regs[2];  // v0 is register 2 in the MIPS ABI

endmodule

// ==== design/store_merge_sequencer.sv ====
`timescale 1ns/10ps

module store_merge_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  mem_write,
  input  ctrl_pkg::store_kind_e store_kind,
  output logic                  stall,
  output logic                  merge_phase,
  output logic                  write_phase
);

  // The read cycle is the idle state seen with a sub-word store present
  localparam logic [1:0] s_idle  = 2'd0;
  localparam logic [1:0] s_merge = 2'd1;
  localparam logic [1:0] s_write = 2'd2;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       sub_word;

  // Only byte and halfword stores need the old memory word
  assign sub_word = mem_write && (store_kind != ctrl_pkg::st_word);

  // PC holds during read and merge, it moves at the end of the write cycle
  assign stall       = ((state_q == s_idle) && sub_word) || (state_q == s_merge);
  assign merge_phase = (state_q == s_merge);
  assign write_phase = (state_q == s_write);

  always_comb begin
    state_d = state_q;
    case (state_q)
      s_idle: begin
        if (sub_word) begin
          state_d = s_merge;  // Word captured this cycle, merge next
        end
      end
      s_merge: state_d = s_write;
      s_write: state_d = s_idle;  // Same instruction is still fetched here, so no retrigger
      default: state_d = s_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= s_idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== design/mips_control.sv ====
`timescale 1ns/10ps

module mips_control (
  input  isa_pkg::instr_t        instr,
  output logic                   reg_write,
  output logic                   reg_dst_rd,
  output logic                   link,
  output logic                   mem_to_reg,
  output logic                   alu_src_imm,
  output logic                   branch,
  output logic                   branch_ne,
  output logic                   jump,
  output logic                   jump_reg,
  output logic                   mem_write,
  output ctrl_pkg::store_kind_e  store_kind,
  output ctrl_pkg::alu_op_e      alu_op,
  output ctrl_pkg::load_kind_e   load_kind
);

  always_comb begin
    // Anything not matched below falls out as a no-op with no writes
    reg_write   = 1'b0;
    reg_dst_rd  = 1'b0;
    link        = 1'b0;
    mem_to_reg  = 1'b0;
    alu_src_imm = 1'b0;
    branch      = 1'b0;
    branch_ne   = 1'b0;
    jump        = 1'b0;
    jump_reg    = 1'b0;
    mem_write   = 1'b0;
    store_kind  = ctrl_pkg::st_word;
    alu_op      = ctrl_pkg::alu_add;  // Address adder for loads and stores
    load_kind   = ctrl_pkg::ld_word;

    case (instr.r_view.opcode)
      isa_pkg::op_special: begin
        reg_dst_rd = 1'b1;  // R-type writes to rd
        reg_write  = 1'b1;  // Cleared again for jr and unknown functs
        case (instr.r_view.funct)
          isa_pkg::fn_addu: alu_op = ctrl_pkg::alu_add;
          isa_pkg::fn_subu: alu_op = ctrl_pkg::alu_sub;
          isa_pkg::fn_and:  alu_op = ctrl_pkg::alu_and;
          isa_pkg::fn_or:   alu_op = ctrl_pkg::alu_or;
          isa_pkg::fn_xor:  alu_op = ctrl_pkg::alu_xor;
          isa_pkg::fn_slt:  alu_op = ctrl_pkg::alu_slt;
          isa_pkg::fn_sll:  alu_op = ctrl_pkg::alu_sll;
          isa_pkg::fn_srl:  alu_op = ctrl_pkg::alu_srl;
          isa_pkg::fn_jr: begin
            jump_reg  = 1'b1;  // Target comes straight from rs
            reg_write = 1'b0;
          end
          default: reg_write = 1'b0;
        endcase
      end
      isa_pkg::op_addiu, isa_pkg::op_andi, isa_pkg::op_ori, isa_pkg::op_lui: begin
        reg_write   = 1'b1;  // Result lands in rt
        alu_src_imm = 1'b1;
        case (instr.r_view.opcode)
          isa_pkg::op_andi: alu_op = ctrl_pkg::alu_and;
          isa_pkg::op_ori:  alu_op = ctrl_pkg::alu_or;
          isa_pkg::op_lui:  alu_op = ctrl_pkg::alu_lui;
          default:          alu_op = ctrl_pkg::alu_add;
        endcase
      end
      isa_pkg::op_lw, isa_pkg::op_lb, isa_pkg::op_lbu, isa_pkg::op_lh, isa_pkg::op_lhu: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        mem_to_reg  = 1'b1;
        case (instr.r_view.opcode)
          isa_pkg::op_lb:  load_kind = ctrl_pkg::ld_byte_s;
          isa_pkg::op_lbu: load_kind = ctrl_pkg::ld_byte_u;
          isa_pkg::op_lh:  load_kind = ctrl_pkg::ld_half_s;
          isa_pkg::op_lhu: load_kind = ctrl_pkg::ld_half_u;
          default:         load_kind = ctrl_pkg::ld_word;
        endcase
      end
      isa_pkg::op_sw, isa_pkg::op_sb, isa_pkg::op_sh: begin
        mem_write   = 1'b1;
        alu_src_imm = 1'b1;
        case (instr.r_view.opcode)
          isa_pkg::op_sb: store_kind = ctrl_pkg::st_byte;
          isa_pkg::op_sh: store_kind = ctrl_pkg::st_half;
          default:        store_kind = ctrl_pkg::st_word;
        endcase
      end
      isa_pkg::op_beq, isa_pkg::op_bne: begin
        branch    = 1'b1;
        branch_ne = (instr.r_view.opcode == isa_pkg::op_bne);  // Inverts the zero test
        alu_op    = ctrl_pkg::alu_sub;
      end
      isa_pkg::op_j: jump = 1'b1;
      isa_pkg::op_jal: begin
        jump      = 1'b1;
        link      = 1'b1;  // Forces register 31 and the PC+8 value
        reg_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== design/mips_datapath.sv ====
`timescale 1ns/10ps

module mips_datapath #(
  parameter logic [31:0] reset_addr = isa_pkg::reset_vector
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  reg_write,
  input  logic                  reg_dst_rd,
  input  logic                  link,
  input  logic                  mem_to_reg,
  input  logic                  alu_src_imm,
  input  logic                  branch,
  input  logic                  branch_ne,
  input  logic                  jump,
  input  logic                  jump_reg,
  input  logic                  mem_write,
  input  ctrl_pkg::store_kind_e store_kind,
  input  ctrl_pkg::alu_op_e     alu_op,
  input  ctrl_pkg::load_kind_e  load_kind,
  input  logic [31:0]           instr_readdata,
  input  logic [31:0]           data_readdata,
  output logic [31:0]           instr_address,
  output logic [31:0]           data_address,
  output logic [31:0]           data_writedata,
  output logic                  data_write,
  output logic [31:0]           register_v0,
  output logic                  active
);

  isa_pkg::instr_t instr;
  logic [31:0] pc_q, pc_next_q, pc_new;  // Current PC and the delay-slot PC behind it
  logic [31:0] pc_plus4, pc_plus8, branch_target, jump_target;
  logic [31:0] rd1, rd2, imm_ext, alu_b, alu_y, load_y, wb_data;
  logic [31:0] merge_q, merged;
  logic [4:0]  wb_addr;
  logic        active_q, stall, merge_phase, write_phase, read_phase;
  logic        alu_zero, branch_taken, sub_store, imm_zero_ext, reg_we;

  assign instr = instr_readdata;
  assign pc_plus4 = pc_q + 32'd4;
  assign pc_plus8 = pc_q + 32'd8;  // Return address skips the delay slot

  // andi and ori are the only immediates feeding a logic operation
  assign imm_zero_ext = alu_op inside {ctrl_pkg::alu_and, ctrl_pkg::alu_or};
  assign imm_ext = imm_zero_ext ? {16'h0, instr.i_view.imm16}
                                : {{16{instr.i_view.imm16[15]}}, instr.i_view.imm16};
  assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr.j_view.target26, 2'b00};
  assign branch_taken  = branch && (alu_zero ^ branch_ne);

  // The chosen target goes into pc_next_q, so the slot already there runs first
  always_comb begin
    if (jump_reg) begin
      pc_new = rd1;
    end else if (jump) begin
      pc_new = jump_target;
    end else if (branch_taken) begin
      pc_new = branch_target;
    end else begin
      pc_new = pc_next_q + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q      <= reset_addr;
      pc_next_q <= reset_addr + 32'd4;
      active_q  <= 1'b1;
    end else if (active_q && !stall) begin
      pc_q      <= pc_next_q;
      pc_next_q <= pc_new;
      active_q  <= (pc_next_q != 32'h0);  // Halts as the core arrives at address 0
    end
  end

  assign wb_addr = link ? 5'd31 : (reg_dst_rd ? instr.r_view.rd : instr.r_view.rt);
  assign wb_data = link ? pc_plus8 : (mem_to_reg ? load_y : alu_y);
  assign reg_we  = reg_write && active_q && !stall;

  reg_file u_reg_file (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (reg_we),
    .ra1    (instr.r_view.rs),
    .ra2    (instr.r_view.rt),
    .wa     (wb_addr),
    .wd     (wb_data),
    .rd1    (rd1),
    .rd2    (rd2),
    .reg_v0 (register_v0)
  );

  assign alu_b = alu_src_imm ? imm_ext : rd2;

  alu u_alu (
    .op    (alu_op),
    .a     (rd1),
    .b     (alu_b),
    .shamt (instr.r_view.shamt),
    .y     (alu_y),
    .zero  (alu_zero)
  );

  load_select u_load_select (
    .word      (data_readdata),
    .byte_addr (alu_y[1:0]),
    .kind      (load_kind),
    .y         (load_y)
  );

  store_merge_sequencer u_store_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_write   (mem_write && active_q),
    .store_kind  (store_kind),
    .stall       (stall),
    .merge_phase (merge_phase),
    .write_phase (write_phase)
  );

  assign sub_store  = mem_write && (store_kind != ctrl_pkg::st_word);
  assign read_phase = stall && !merge_phase;  // First cycle of SB or SH

  // Lane positions follow the big-endian order used by the loads
  always_comb begin
    merged = merge_q;
    if (store_kind == ctrl_pkg::st_byte) begin
      merged[8 * (3 - alu_y[1:0]) +: 8] = rd2[7:0];
    end else if (alu_y[1]) begin
      merged[15:0] = rd2[15:0];
    end else begin
      merged[31:16] = rd2[15:0];
    end
  end

  always_ff @(posedge clk) begin
    if (read_phase) begin
      merge_q <= data_readdata;
    end else if (merge_phase) begin
      merge_q <= merged;
    end
  end

  // The whole SB or SH sequence addresses the containing word
  assign data_address   = sub_store ? {alu_y[31:2], 2'b00} : alu_y;
  assign data_writedata = write_phase ? merge_q : rd2;
  assign data_write     = mem_write && active_q && (!sub_store || write_phase);

  assign instr_address = pc_q;
  assign active        = active_q;

endmodule

// ==== design/mips_core.sv ====
`timescale 1ns/10ps

module mips_core #(
  parameter logic [31:0] reset_addr = isa_pkg::reset_vector
) (
  input  logic        clk,
  input  logic        rst_n,
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  output logic [31:0] data_address,
  output logic [31:0] data_writedata,
  output logic        data_write,
  input  logic [31:0] data_readdata,
  output logic [31:0] register_v0,
  output logic        active
);

  logic reg_write, reg_dst_rd, link, mem_to_reg, alu_src_imm;
  logic branch, branch_ne, jump, jump_reg, mem_write;
  ctrl_pkg::store_kind_e store_kind;
  ctrl_pkg::alu_op_e     alu_op;
  ctrl_pkg::load_kind_e  load_kind;

  // Decoder sees the same fetched word as the datapath
  mips_control u_control (
    .instr       (instr_readdata),
    .reg_write   (reg_write),
    .reg_dst_rd  (reg_dst_rd),
    .link        (link),
    .mem_to_reg  (mem_to_reg),
    .alu_src_imm (alu_src_imm),
    .branch      (branch),
    .branch_ne   (branch_ne),
    .jump        (jump),
    .jump_reg    (jump_reg),
    .mem_write   (mem_write),
    .store_kind  (store_kind),
    .alu_op      (alu_op),
    .load_kind   (load_kind)
  );

  mips_datapath #(.reset_addr(reset_addr)) u_datapath (
    .clk            (clk),
    .rst_n          (rst_n),
    .reg_write      (reg_write),
    .reg_dst_rd     (reg_dst_rd),
    .link           (link),
    .mem_to_reg     (mem_to_reg),
    .alu_src_imm    (alu_src_imm),
    .branch         (branch),
    .branch_ne      (branch_ne),
    .jump           (jump),
    .jump_reg       (jump_reg),
    .mem_write      (mem_write),
    .store_kind     (store_kind),
    .alu_op         (alu_op),
    .load_kind      (load_kind),
    .instr_readdata (instr_readdata),
    .data_readdata  (data_readdata),
    .instr_address  (instr_address),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .register_v0    (register_v0),
    .active         (active)
  );

endmodule

// ==== test/mips_core_assert.sv ====
`timescale 1ns/10ps

module mips_core_assert #(
  parameter logic [31:0] reset_addr = isa_pkg::reset_vector
) (
  input logic        clk,
  input logic        rst_n,
  input logic [31:0] instr_address,
  input logic [31:0] data_address,
  input logic        data_write,
  input logic        active,
  input logic        stall
);

  int failures = 0;

  // The first fetch after reset comes from the boot address
  boot_fetch: assert property (@(posedge clk) $rose(rst_n) |-> instr_address == reset_addr)
    else begin
      failures++;
      $error("instr_address does not hold the reset address after reset");
    end

  // A halted core leaves memory alone
  halted_quiet: assert property (@(posedge clk) disable iff (!rst_n) !active |-> !data_write)
    else begin
      failures++;
      $error("data_write is high while the core is halted");
    end

  // Memory is word wide, sub-word stores go through the merge path
  aligned_write: assert property (@(posedge clk) disable iff (!rst_n)
                                  data_write |-> data_address[1:0] == 2'b00)
    else begin
      failures++;
      $error("data_write is high with a data_address that is not word aligned");
    end

  stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
                                   $rose(stall) |=> $stable(instr_address))
    else begin
      failures++;
      $error("instr_address moved while a byte or halfword store was stalling");
    end

endmodule

// Stall is internal to the datapath, so it is picked up by hierarchical name
bind mips_core mips_core_assert #(.reset_addr(reset_addr)) u_assert (
  .clk           (clk),
  .rst_n         (rst_n),
  .instr_address (instr_address),
  .data_address  (data_address),
  .data_write    (data_write),
  .active        (active),
  .stall         (u_datapath.stall)
);

// ==== test/tb_mips_core.sv ====
`timescale 1ns/10ps

module tb_mips_core;

  localparam int clk_period = 8;
  localparam logic [31:0] reset_addr = isa_pkg::reset_vector;
  // Fetches outside the program see a word store that must never reach memory
  localparam logic [31:0] halt_fetch = {isa_pkg::op_sw, 5'd0, 5'd10, 16'h0040};
  localparam int sub_idx = 200;  // Word index of the subroutine called by jal

  logic        clk;
  logic        rst_n;
  logic [31:0] instr_address, instr_readdata, data_address, data_writedata, data_readdata;
  logic [31:0] register_v0, fetch_off;
  logic        data_write, active;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] ref_mem [256];  // Expected memory contents
  logic [31:0] m [32];         // Expected register contents
  logic [31:0] exp_v0 [$];     // Expected v0 after each executed instruction, in run order
  int          exp_midx [$];   // Word written by that instruction, -1 when none
  logic [31:0] exp_mword [$];
  int          cursor, n_placed, mismatches, other_errors;
  bit          built;

  mips_core #(.reset_addr(reset_addr)) dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .data_readdata  (data_readdata),
    .register_v0    (register_v0),
    .active         (active)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  // Program memory starts at the reset address, data memory at zero
  assign fetch_off      = instr_address - reset_addr;
  assign instr_readdata = (fetch_off < 32'd1024) ? imem[fetch_off[9:2]] : halt_fetch;
  assign data_readdata  = dmem[data_address[9:2]];

  always @(posedge clk) begin
    if (data_write) begin
      dmem[data_address[9:2]] <= data_writedata;
    end
  end

  function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd,
                                        input logic [4:0] sh);
    return {isa_pkg::op_special, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Big-endian lanes, offset 0 is the top byte
  function automatic logic [7:0] byte_at(input logic [31:0] w, input int off);
    case (off)
      0: return w[31:24];
      1: return w[23:16];
      2: return w[15:8];
      default: return w[7:0];
    endcase
  endfunction

  function automatic logic [15:0] half_at(input logic [31:0] w, input int off);
    return (off < 2) ? w[31:16] : w[15:0];
  endfunction

  function automatic logic [31:0] set_byte(input logic [31:0] w, input int off,
                                           input logic [7:0] v);
    case (off)
      0: w[31:24] = v;
      1: w[23:16] = v;
      2: w[15:8] = v;
      default: w[7:0] = v;
    endcase
    return w;
  endfunction

  // Places one word at the cursor and, when it runs, queues what it should leave behind
  task automatic place(input logic [31:0] word, input bit runs, input int midx);
    imem[cursor] = word;
    cursor++;
    n_placed++;
    if (runs) begin
      exp_v0.push_back(m[2]);
      exp_midx.push_back(midx);
      exp_mword.push_back((midx >= 0) ? ref_mem[midx] : 32'h0);
    end
  endtask

  task automatic alu_step(input logic [31:0] word, input logic [4:0] dst,
                          input logic [31:0] val);
    if (dst != 5'd0) begin
      m[dst] = val;  // Register 0 stays zero
    end
    place(word, 1'b1, -1);
  endtask

  task automatic load_const(input logic [4:0] r, input logic [31:0] val);
    alu_step(enc_i(isa_pkg::op_lui, 5'd0, r, val[31:16]), r, {val[31:16], 16'h0});
    alu_step(enc_i(isa_pkg::op_ori, r, r, val[15:0]), r, val);
  endtask

  // Stores register 10 into word idx at byte offset off
  task automatic store_step(input logic [5:0] op, input int idx, input int off);
    case (op)
      isa_pkg::op_sb: ref_mem[idx] = set_byte(ref_mem[idx], off, m[10][7:0]);
      isa_pkg::op_sh: begin
        if (off < 2) ref_mem[idx][31:16] = m[10][15:0];
        else ref_mem[idx][15:0] = m[10][15:0];
      end
      default: ref_mem[idx] = m[10];
    endcase
    place(enc_i(op, 5'd0, 5'd10, 16'(4 * idx + off)), 1'b1, idx);
  endtask

  // Branch, delay slot, fall-through word, then the target two words past the slot
  task automatic branch_case(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt);
    bit taken;
    taken = (m[rs] == m[rt]) ^ (op == isa_pkg::op_bne);
    alu_step(enc_i(op, rs, rt, 16'd2), 5'd0, 32'h0);
    alu_step(enc_i(isa_pkg::op_addiu, 5'd2, 5'd2, 16'h1), 5'd2, m[2] + 32'h1);
    if (!taken) m[2] = m[2] + 32'h40;
    place(enc_i(isa_pkg::op_addiu, 5'd2, 5'd2, 16'h40), !taken, -1);
    alu_step(enc_i(isa_pkg::op_addiu, 5'd2, 5'd2, 16'h100), 5'd2, m[2] + 32'h100);
  endtask

  // An instruction retired, v0 and any stored word must match the queued values
  task automatic check_retire();
    logic [31:0] want, mword;
    int midx;
    if (exp_v0.size() == 0) begin
      other_errors++;
      $display("The core ran past the end of the program at %0t", $time);
      return;
    end
    want  = exp_v0.pop_front();
    midx  = exp_midx.pop_front();
    mword = exp_mword.pop_front();
    assert (register_v0 == want) else begin
      mismatches++;
      $display("Mismatch at %0t: v0 is %h, expected %h", $time, register_v0, want);
    end
    if (midx >= 0) begin
      assert (dmem[midx] == mword) else begin
        mismatches++;
        $display("Mismatch at %0t: word %0d is %h, expected %h", $time, midx, dmem[midx], mword);
      end
    end
  endtask

  initial begin : watchdog
    wait (built);
    #(40 * n_placed * clk_period);
    $display("Timeout: the core did not halt within %0d cycles", 40 * n_placed);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : main
    logic [31:0] a, b, x, w, last_addr;
    logic [15:0] imm, hv;
    logic [7:0]  bv;
    logic [4:0]  sh;
    int          ret_idx;
    void'($urandom(32'h917c_8b25));
    rst_n = 1'b0;
    mismatches = 0;
    other_errors = 0;
    cursor = 0;
    n_placed = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0;  // sll $0,$0,0 does nothing
      dmem[i] = $urandom;
      ref_mem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) m[i] = 32'h0;

    // ALU and immediate operations on random operands
    a = $urandom;
    b = $urandom;
    sh = 5'($urandom);
    imm = 16'($urandom);
    load_const(5'd8, a);
    load_const(5'd9, b);
    alu_step(enc_r(isa_pkg::fn_addu, 5'd8, 5'd9, 5'd2, 5'd0), 5'd2, a + b);
    alu_step(enc_r(isa_pkg::fn_subu, 5'd8, 5'd9, 5'd2, 5'd0), 5'd2, a - b);
    alu_step(enc_r(isa_pkg::fn_and, 5'd8, 5'd9, 5'd2, 5'd0), 5'd2, a & b);
    alu_step(enc_r(isa_pkg::fn_or, 5'd8, 5'd9, 5'd2, 5'd0), 5'd2, a | b);
    alu_step(enc_r(isa_pkg::fn_xor, 5'd8, 5'd9, 5'd2, 5'd0), 5'd2, a ^ b);
    alu_step(enc_r(isa_pkg::fn_slt, 5'd8, 5'd9, 5'd2, 5'd0), 5'd2,
             {31'h0, $signed(a) < $signed(b)});
    alu_step(enc_r(isa_pkg::fn_slt, 5'd9, 5'd8, 5'd2, 5'd0), 5'd2,
             {31'h0, $signed(b) < $signed(a)});
    alu_step(enc_r(isa_pkg::fn_sll, 5'd0, 5'd9, 5'd2, sh), 5'd2, b << sh);
    alu_step(enc_r(isa_pkg::fn_srl, 5'd0, 5'd9, 5'd2, sh), 5'd2, b >> sh);
    alu_step(enc_i(isa_pkg::op_addiu, 5'd8, 5'd2, imm), 5'd2, a + {{16{imm[15]}}, imm});
    alu_step(enc_i(isa_pkg::op_andi, 5'd8, 5'd2, imm), 5'd2, a & {16'h0, imm});
    alu_step(enc_i(isa_pkg::op_ori, 5'd8, 5'd2, imm), 5'd2, a | {16'h0, imm});
    alu_step(enc_i(isa_pkg::op_lui, 5'd0, 5'd2, imm), 5'd2, {imm, 16'h0});

    // Loads from word n at byte offset n
    for (int off = 0; off < 4; off++) begin
      w = ref_mem[off];
      bv = byte_at(w, off);
      hv = half_at(w, off);
      alu_step(enc_i(isa_pkg::op_lb, 5'd0, 5'd2, 16'(5 * off)), 5'd2, {{24{bv[7]}}, bv});
      alu_step(enc_i(isa_pkg::op_lbu, 5'd0, 5'd2, 16'(5 * off)), 5'd2, {24'h0, bv});
      if (off % 2 == 0) begin
        alu_step(enc_i(isa_pkg::op_lh, 5'd0, 5'd2, 16'(5 * off)), 5'd2, {{16{hv[15]}}, hv});
        alu_step(enc_i(isa_pkg::op_lhu, 5'd0, 5'd2, 16'(5 * off)), 5'd2, {16'h0, hv});
      end
    end
    alu_step(enc_i(isa_pkg::op_lw, 5'd0, 5'd2, 16'h10), 5'd2, ref_mem[4]);

    // Stores, each with fresh data in register 10
    for (int off = 0; off < 4; off++) begin
      load_const(5'd10, $urandom);
      store_step(isa_pkg::op_sb, 16 + off, off);
    end
    for (int off = 0; off < 4; off += 2) begin
      load_const(5'd10, $urandom);
      store_step(isa_pkg::op_sh, 20 + off / 2, off);
    end
    load_const(5'd10, $urandom);
    store_step(isa_pkg::op_sw, 24, 0);

    // Branches, taken and not taken, with v0 tracing the path
    x = $urandom;
    load_const(5'd11, x);
    load_const(5'd12, x);
    load_const(5'd13, x ^ 32'h0000_0100);
    alu_step(enc_r(isa_pkg::fn_addu, 5'd0, 5'd0, 5'd2, 5'd0), 5'd2, 32'h0);
    branch_case(isa_pkg::op_beq, 5'd11, 5'd12);
    branch_case(isa_pkg::op_bne, 5'd11, 5'd13);
    branch_case(isa_pkg::op_beq, 5'd11, 5'd13);
    branch_case(isa_pkg::op_bne, 5'd11, 5'd12);

    // Call and return, the subroutine sits higher in program memory
    alu_step({isa_pkg::op_jal, 26'((reset_addr + 32'(4 * sub_idx)) >> 2)}, 5'd31,
             reset_addr + 32'(4 * cursor) + 32'd8);
    alu_step(enc_i(isa_pkg::op_addiu, 5'd0, 5'd2, 16'h3), 5'd2, 32'h3);
    ret_idx = cursor;
    cursor = sub_idx;
    alu_step(enc_r(isa_pkg::fn_addu, 5'd31, 5'd0, 5'd2, 5'd0), 5'd2, m[31]);
    alu_step(enc_r(isa_pkg::fn_jr, 5'd31, 5'd0, 5'd0, 5'd0), 5'd0, 32'h0);
    alu_step(enc_i(isa_pkg::op_addiu, 5'd2, 5'd2, 16'h4), 5'd2, m[2] + 32'h4);
    cursor = ret_idx;
    alu_step(enc_r(isa_pkg::fn_subu, 5'd2, 5'd31, 5'd2, 5'd0), 5'd2, m[2] - m[31]);

    // Jump through register 0 stops the core after its delay slot
    alu_step(enc_r(isa_pkg::fn_jr, 5'd0, 5'd0, 5'd0, 5'd0), 5'd0, 32'h0);
    alu_step(enc_i(isa_pkg::op_addiu, 5'd2, 5'd2, 16'h20), 5'd2, m[2] + 32'h20);
    built = 1'b1;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (instr_address == reset_addr && !data_write) else begin
      mismatches++;
      $display("Mismatch at %0t: after reset instr_address %h data_write %b",
               $time, instr_address, data_write);
    end

    // A new fetch address means the previous instruction has finished
    last_addr = reset_addr;
    while (active) begin
      @(negedge clk);
      if (instr_address != last_addr) begin
        check_retire();
        last_addr = instr_address;
      end
    end
    repeat (3) @(negedge clk);  // Halted core must stay quiet

    if (exp_v0.size() != 0) begin
      other_errors++;
      $display("The core halted with %0d program instructions never executed", exp_v0.size());
    end
    assert (register_v0 == m[2]) else begin
      mismatches++;
      $display("Mismatch at %0t: final v0 is %h, expected %h", $time, register_v0, m[2]);
    end
    for (int i = 0; i < 256; i++) begin
      assert (dmem[i] == ref_mem[i]) else begin
        mismatches++;
        $display("Mismatch at %0t: final word %0d is %h, expected %h",
                 $time, i, dmem[i], ref_mem[i]);
      end
    end

    $display("Run finished with %0d mismatches, %0d other errors, %0d assertion failures",
             mismatches, other_errors, dut0.u_assert.failures);
    if (mismatches + other_errors + dut0.u_assert.failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== project.f ====
design/isa_pkg.sv
design/ctrl_pkg.sv
design/alu.sv
design/load_select.sv
design/reg_file.sv
design/store_merge_sequencer.sv
design/mips_control.sv
design/mips_datapath.sv
design/mips_core.sv
test/mips_core_assert.sv
test/tb_mips_core.sv
